// ==== branch_pkg.sv ====
`default_nettype none

package branch_pkg;

        // --------------------------------------------------
        // machine word and opcode field
        // --------------------------------------------------
        typedef logic [15:0] word_t;
        typedef logic [3:0]  opcode_t;

        localparam opcode_t OP_BNE = 4'd0;
        localparam opcode_t OP_BEQ = 4'd1;
        localparam opcode_t OP_BGZ = 4'd2;
        localparam opcode_t OP_BLZ = 4'd3;
        localparam opcode_t OP_JMP = 4'd9;

        // --------------------------------------------------
        // instruction word, two decodings of the same bits
        // --------------------------------------------------
        typedef struct packed {
                opcode_t    opcode;
                logic [1:0] rs;
                logic [1:0] rt;
                logic [7:0] imm;
        } i_view_t;

        typedef struct packed {
                opcode_t     opcode;
                logic [11:0] target;
        } j_view_t;

        typedef union packed {
                i_view_t i_view;
                j_view_t j_view;
        } instr_u;

        // --------------------------------------------------
        // two-bit saturating counter
        // --------------------------------------------------
        typedef logic [1:0] ctr_t;

        localparam ctr_t CTR_STRONG_NOT   = 2'd0;
        localparam ctr_t CTR_WEAK_NOT     = 2'd1;
        localparam ctr_t CTR_WEAK_TAKEN   = 2'd2;
        localparam ctr_t CTR_STRONG_TAKEN = 2'd3;

        // 16 entries
        localparam int BTB_INDEX_BITS_DEFAULT = 4;

endpackage

`default_nettype wire

// ==== resolve_if.sv ====
`timescale 1ns/1ps
`default_nettype none

interface resolve_if;

        // branch or jump resolved this cycle
        logic              valid;
        // address of the resolved instruction
        branch_pkg::word_t pc;
        logic              taken;
        branch_pkg::word_t target;
        // real next address after the resolved instruction
        branch_pkg::word_t next_pc;
        logic              miss;

        modport src (output valid, pc, taken, target, next_pc, miss);

        // table update side
        modport predictor (input valid, pc, taken, target);

        // fetch redirect and counters
        modport steer (input valid, miss, next_pc);

endinterface

`default_nettype wire

// ==== branch_resolver.sv ====
`timescale 1ns/1ps
`default_nettype none

module branch_resolver (
        input  wire logic              i_ex_valid,
        input  wire branch_pkg::word_t i_ex_instr,
        input  wire branch_pkg::word_t i_ex_pc,
        input  wire branch_pkg::word_t i_ex_predicted_pc,
        input  wire branch_pkg::word_t i_ex_rs_data,
        input  wire branch_pkg::word_t i_ex_rt_data,
        resolve_if.src                 res
);

        branch_pkg::instr_u instr;
        branch_pkg::word_t  pc_plus_one;
        branch_pkg::word_t  imm_ext;
        branch_pkg::word_t  i_target;
        branch_pkg::word_t  j_target;
        branch_pkg::word_t  target;
        branch_pkg::word_t  next_pc;
        logic               is_branch;
        logic               is_jump;
        logic               cond;
        logic               resolve_valid;

        assign instr = i_ex_instr;

        // --------------------------------------------------
        // targets
        // --------------------------------------------------
        assign pc_plus_one = i_ex_pc + 16'd1;
        assign imm_ext     = {{8{instr.i_view.imm[7]}}, instr.i_view.imm};
        assign i_target    = pc_plus_one + imm_ext;
        // jump keeps the top nibble of its own address
        assign j_target    = {i_ex_pc[15:12], instr.j_view.target};
        assign is_jump     = instr.j_view.opcode == branch_pkg::OP_JMP;
        assign target      = is_jump ? j_target : i_target;

        // --------------------------------------------------
        // condition per opcode
        // --------------------------------------------------
        always_comb begin
                is_branch = 1'b1;
                cond      = 1'b0;
                case (instr.i_view.opcode)
                        branch_pkg::OP_BNE: cond = i_ex_rs_data != i_ex_rt_data;
                        branch_pkg::OP_BEQ: cond = i_ex_rs_data == i_ex_rt_data;
                        branch_pkg::OP_BGZ: cond = $signed(i_ex_rs_data) > 0;
                        branch_pkg::OP_BLZ: cond = $signed(i_ex_rs_data) < 0;
                        branch_pkg::OP_JMP: cond = 1'b1;
                        default:            is_branch = 1'b0;
                endcase
        end

        assign resolve_valid = i_ex_valid && is_branch;
        assign next_pc       = cond ? target : pc_plus_one;

        assign res.valid   = resolve_valid;
        assign res.pc      = i_ex_pc;
        assign res.taken   = cond;
        assign res.target  = target;
        assign res.next_pc = next_pc;
        // fetch went down the wrong path
        assign res.miss    = resolve_valid && (next_pc != i_ex_predicted_pc);

        // miss settles to a known level
        always_comb begin
                assert final (!$isunknown(res.miss))
                else $error("miss flag is not a known level");
        end

endmodule

`default_nettype wire

// ==== branch_predictor.sv ====
`timescale 1ns/1ps
`default_nettype none

module branch_predictor #(
        parameter int BTB_INDEX_BITS = branch_pkg::BTB_INDEX_BITS_DEFAULT
) (
        input  wire logic              clk,
        input  wire logic              reset_n,
        input  wire branch_pkg::word_t i_fetch_pc,
        output branch_pkg::word_t      o_predicted_pc,
        resolve_if.predictor           res
);

        localparam int ENTRIES  = 1 << BTB_INDEX_BITS;
        localparam int TAG_BITS = 16 - BTB_INDEX_BITS;

        logic [TAG_BITS-1:0] tag_mem    [ENTRIES];
        branch_pkg::word_t   target_mem [ENTRIES];
        branch_pkg::ctr_t    ctr_mem    [ENTRIES];

        logic [BTB_INDEX_BITS-1:0] rd_index;
        logic [BTB_INDEX_BITS-1:0] wr_index;
        logic [TAG_BITS-1:0]       rd_tag;
        logic [TAG_BITS-1:0]       wr_tag;
        logic                      rd_hit;
        logic                      wr_match;
        branch_pkg::ctr_t          ctr_next;

        assign rd_index = i_fetch_pc[BTB_INDEX_BITS-1:0];
        assign rd_tag   = i_fetch_pc[15:BTB_INDEX_BITS];
        assign wr_index = res.pc[BTB_INDEX_BITS-1:0];
        assign wr_tag   = res.pc[15:BTB_INDEX_BITS];

        // --------------------------------------------------
        // lookup
        // --------------------------------------------------
        always_comb begin
                rd_hit   = 1'b0;
                wr_match = 1'b0;
                // never-written tags fall to the no-match side
                if (tag_mem[rd_index] == rd_tag)
                        rd_hit = 1'b1;
                if (tag_mem[wr_index] == wr_tag)
                        wr_match = 1'b1;
        end

        assign o_predicted_pc = (rd_hit && ctr_mem[rd_index] >= branch_pkg::CTR_WEAK_TAKEN) ?
                                target_mem[rd_index] : i_fetch_pc + 16'd1;

        // --------------------------------------------------
        // update on resolve
        // --------------------------------------------------
        always_comb begin
                ctr_next = ctr_mem[wr_index];
                if (wr_match) begin
                        if (res.taken && ctr_next != branch_pkg::CTR_STRONG_TAKEN)
                                ctr_next = ctr_next + 2'd1;
                        else if (!res.taken && ctr_next != branch_pkg::CTR_STRONG_NOT)
                                ctr_next = ctr_next - 2'd1;
                end else begin
                        // fresh entry starts weak
                        ctr_next = res.taken ? branch_pkg::CTR_WEAK_TAKEN :
                                               branch_pkg::CTR_WEAK_NOT;
                end
        end

        always_ff @(posedge clk) begin
                if (res.valid && !wr_match) begin
                        tag_mem[wr_index]    <= wr_tag;
                        target_mem[wr_index] <= res.target;
                end
        end

        always_ff @(posedge clk) begin
                if (!reset_n) begin
                        for (int i = 0; i < ENTRIES; i++)
                                ctr_mem[i] <= branch_pkg::CTR_STRONG_NOT;
                end else if (res.valid) begin
                        ctr_mem[wr_index] <= ctr_next;
                end
        end

        // updated counter holds a known value in range
        ctr_in_range: assert property (@(posedge clk) disable iff (!reset_n)
                res.valid |=> ctr_mem[$past(wr_index)] inside
                        {[branch_pkg::CTR_STRONG_NOT:branch_pkg::CTR_STRONG_TAKEN]})
        else $error("counter out of range after update");

endmodule

`default_nettype wire

// ==== fetch_pc_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module fetch_pc_unit (
        input  wire logic              clk,
        input  wire logic              reset_n,
        input  wire logic              i_stall,
        input  wire branch_pkg::word_t i_predicted_pc,
        output branch_pkg::word_t      o_pc,
        output logic                   o_redirect,
        output branch_pkg::word_t      o_num_branch,
        output branch_pkg::word_t      o_num_miss,
        resolve_if.steer               res
);

        branch_pkg::word_t pc_next;

        // --------------------------------------------------
        // redirect choice
        // --------------------------------------------------
        // a miss in execute overrides the prediction
        assign o_redirect = res.miss;
        assign pc_next    = res.miss ? res.next_pc : i_predicted_pc;

        always_ff @(posedge clk) begin
                if (!reset_n) begin
                        o_pc <= '0;
                end else if (!i_stall) begin
                        o_pc <= pc_next;
                end
        end

        // --------------------------------------------------
        // branch and miss counters
        // --------------------------------------------------
        always_ff @(posedge clk) begin
                if (!reset_n) begin
                        o_num_branch <= '0;
                        o_num_miss   <= '0;
                end else if (!i_stall) begin
                        if (res.valid)
                                o_num_branch <= o_num_branch + 16'd1;
                        if (res.miss)
                                o_num_miss <= o_num_miss + 16'd1;
                end
        end

        // execute stage is empty while fetch is stalled
        no_resolve_in_stall: assert property (@(posedge clk) disable iff (!reset_n)
                i_stall |-> !res.valid)
        else $error("branch resolved during stall");

endmodule

`default_nettype wire

// ==== branch_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module branch_unit #(
        parameter int BTB_INDEX_BITS = branch_pkg::BTB_INDEX_BITS_DEFAULT
) (
        input  wire logic              clk,
        input  wire logic              reset_n,
        input  wire logic              i_stall,
        input  wire logic              i_ex_valid,
        input  wire branch_pkg::word_t i_ex_instr,
        input  wire branch_pkg::word_t i_ex_pc,
        input  wire branch_pkg::word_t i_ex_predicted_pc,
        input  wire branch_pkg::word_t i_ex_rs_data,
        input  wire branch_pkg::word_t i_ex_rt_data,
        output branch_pkg::word_t      o_pc,
        output branch_pkg::word_t      o_predicted_pc,
        output logic                   o_redirect,
        output branch_pkg::word_t      o_num_branch,
        output branch_pkg::word_t      o_num_miss
);

        // resolve results from execute
        resolve_if res_bus ();

        // --------------------------------------------------
        // execute stage resolve
        // --------------------------------------------------
        branch_resolver resolver0 (
                .i_ex_valid        (i_ex_valid),
                .i_ex_instr        (i_ex_instr),
                .i_ex_pc           (i_ex_pc),
                .i_ex_predicted_pc (i_ex_predicted_pc),
                .i_ex_rs_data      (i_ex_rs_data),
                .i_ex_rt_data      (i_ex_rt_data),
                .res               (res_bus.src)
        );

        // lookup runs on the current fetch address
        branch_predictor #(
                .BTB_INDEX_BITS (BTB_INDEX_BITS)
        ) predictor0 (
                .clk            (clk),
                .reset_n        (reset_n),
                .i_fetch_pc     (o_pc),
                .o_predicted_pc (o_predicted_pc),
                .res            (res_bus.predictor)
        );

        // --------------------------------------------------
        // fetch address and counters
        // --------------------------------------------------
        fetch_pc_unit fetch0 (
                .clk            (clk),
                .reset_n        (reset_n),
                .i_stall        (i_stall),
                .i_predicted_pc (o_predicted_pc),
                .o_pc           (o_pc),
                .o_redirect     (o_redirect),
                .o_num_branch   (o_num_branch),
                .o_num_miss     (o_num_miss),
                .res            (res_bus.steer)
        );

endmodule

`default_nettype wire

// ==== branch_checker.sv ====
`timescale 1ns/1ps
`default_nettype none

module branch_checker (
        input  wire logic         clk,
        input  wire logic         reset_n,
        input  wire logic         i_check,
        input  wire logic [127:0] i_test_name,
        // {pc, predicted pc, branch count, miss count, redirect}
        input  wire logic [64:0]  i_actual,
        input  wire logic [64:0]  i_expected,
        output int                o_errors
);

        int error_count = 0;

        assign o_errors = error_count;

        task automatic compare_field(input string name, input branch_pkg::word_t exp_val,
                                     input branch_pkg::word_t act_val);
                if (act_val !== exp_val) begin
                        error_count = error_count + 1;
                        $display("Error: test %0s, %0s expected %h, actual %h at %0t",
                                 i_test_name, name, exp_val, act_val, $time);
                end
        endtask

        // --------------------------------------------------
        // compare before the edge updates anything
        // --------------------------------------------------
        always @(posedge clk) begin
                if (reset_n && i_check) begin
                        compare_field("o_pc", i_expected[64:49], i_actual[64:49]);
                        compare_field("o_predicted_pc", i_expected[48:33], i_actual[48:33]);
                        compare_field("o_num_branch", i_expected[32:17], i_actual[32:17]);
                        compare_field("o_num_miss", i_expected[16:1], i_actual[16:1]);
                        // one bit, shown widened
                        compare_field("o_redirect", i_expected[0], i_actual[0]);
                end
        end

endmodule

`default_nettype wire

// ==== tb_branch_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_branch_unit;

        localparam int ENTRIES    = 1 << branch_pkg::BTB_INDEX_BITS_DEFAULT;
        localparam int NUM_RANDOM = 200;
        // directed part plus at most three cycles per random step
        localparam int NUM_CYCLES = 40 + 3 * NUM_RANDOM;

        logic              clk = 1'b0;
        logic              reset_n, i_stall, i_ex_valid, o_redirect, check_en;
        branch_pkg::word_t i_ex_instr, i_ex_pc, i_ex_predicted_pc, i_ex_rs_data, i_ex_rt_data;
        branch_pkg::word_t o_pc, o_predicted_pc, o_num_branch, o_num_miss;
        logic [64:0]       expected;
        logic [127:0]      test_name;
        int                errors;

        // reference model state
        branch_pkg::word_t m_pc = '0;
        branch_pkg::word_t m_nb = '0;
        branch_pkg::word_t m_nm = '0;
        branch_pkg::word_t m_tag [ENTRIES];
        branch_pkg::word_t m_target [ENTRIES];
        int                m_ctr [ENTRIES];
        bit                m_written [ENTRIES];

        // resolve addresses for the random part, some share an index
        branch_pkg::word_t pool [6] = '{16'h0013, 16'h0023, 16'h1105, 16'h2a07, 16'h0049, 16'hf3f0};
        branch_pkg::word_t pool_pred [6];

        always #20 clk = ~clk;

        branch_unit #(.BTB_INDEX_BITS(branch_pkg::BTB_INDEX_BITS_DEFAULT)) dut0 (.*);

        branch_checker checker0 (
                .clk         (clk),
                .reset_n     (reset_n),
                .i_check     (check_en),
                .i_test_name (test_name),
                .i_actual    ({o_pc, o_predicted_pc, o_num_branch, o_num_miss, o_redirect}),
                .i_expected  (expected),
                .o_errors    (errors)
        );

        // --------------------------------------------------
        // reference model
        // --------------------------------------------------
        // outputs expected before the next edge, then the model steps past it
        function automatic logic [64:0] ref_cycle(input logic stall, valid,
                        input branch_pkg::word_t instr, pc, pred, rs, rt);
                int                idx;
                int                fidx;
                logic              taken;
                logic              is_br;
                logic              miss;
                branch_pkg::word_t target;
                branch_pkg::word_t nxt;
                branch_pkg::word_t pred_now;
                idx    = pc % ENTRIES;
                fidx   = m_pc % ENTRIES;
                taken  = 1'b0;
                is_br  = 1'b1;
                target = pc + 16'd1 + {{8{instr[7]}}, instr[7:0]};
                case (instr[15:12])
                        branch_pkg::OP_BNE: taken = rs != rt;
                        branch_pkg::OP_BEQ: taken = rs == rt;
                        branch_pkg::OP_BGZ: taken = $signed(rs) > 0;
                        branch_pkg::OP_BLZ: taken = $signed(rs) < 0;
                        branch_pkg::OP_JMP: begin
                                taken  = 1'b1;
                                target = {pc[15:12], instr[11:0]};
                        end
                        default: is_br = 1'b0;
                endcase
                nxt      = taken ? target : pc + 16'd1;
                miss     = valid && is_br && nxt != pred;
                pred_now = m_pc + 16'd1;
                if (m_written[fidx] && m_tag[fidx] == m_pc / ENTRIES && m_ctr[fidx] >= 2)
                        pred_now = m_target[fidx];
                ref_cycle = {m_pc, pred_now, m_nb, m_nm, miss};
                if (!stall) begin
                        m_pc = miss ? nxt : pred_now;
                        m_nb += valid && is_br;
                        m_nm += miss;
                end
                if (valid && is_br) begin
                        if (m_written[idx] && m_tag[idx] == pc / ENTRIES) begin
                                m_ctr[idx] = taken ? m_ctr[idx] + (m_ctr[idx] < 3) :
                                                     m_ctr[idx] - (m_ctr[idx] > 0);
                        end else begin
                                m_written[idx] = 1'b1;
                                m_tag[idx]     = pc / ENTRIES;
                                m_target[idx]  = target;
                                m_ctr[idx]     = taken ? 2 : 1;
                        end
                end
        endfunction

        // called on a falling edge, returns on the next one
        task automatic run_cycle(input logic stall, valid,
                                 input branch_pkg::word_t instr, pc, pred, rs, rt);
                foreach (pool[k])
                        if (o_pc == pool[k])
                                pool_pred[k] = o_predicted_pc;
                i_stall           = stall;
                i_ex_valid        = valid;
                i_ex_instr        = instr;
                i_ex_pc           = pc;
                i_ex_predicted_pc = pred;
                i_ex_rs_data      = rs;
                i_ex_rt_data      = rt;
                expected          = ref_cycle(stall, valid, instr, pc, pred, rs, rt);
                check_en          = 1'b1;
                @(negedge clk);
        endtask

        task automatic idle(input int n, input logic stall);
                repeat (n) run_cycle(stall, 1'b0, '0, '0, '0, '0, '0);
        endtask

        // mispredicted JMP from a spare slot, fetch lands on addr next cycle
        task automatic jump_fetch_to(input branch_pkg::word_t addr);
                branch_pkg::word_t jpc;
                jpc = {addr[15:12], 12'hf0e};
                run_cycle(1'b0, 1'b1, {branch_pkg::OP_JMP, addr[11:0]}, jpc, jpc + 16'd1, '0, '0);
        endtask

        // --------------------------------------------------
        // stimulus
        // --------------------------------------------------
        initial begin
                branch_pkg::word_t instr, pred, rs, rt;
                logic [3:0]        op;
                int                k;
                void'($urandom(32'h6dd0_6152));
                reset_n           = 1'b0;
                i_stall           = 1'b0;
                i_ex_valid        = 1'b0;
                i_ex_instr        = '0;
                i_ex_pc           = '0;
                i_ex_predicted_pc = '0;
                i_ex_rs_data      = '0;
                i_ex_rt_data      = '0;
                check_en          = 1'b0;
                expected          = '0;
                foreach (pool[i])
                        pool_pred[i] = pool[i] + 16'd1;
                test_name = "reset";
                repeat (2) @(negedge clk);
                reset_n = 1'b1;
                idle(1, 1'b0);
                test_name = "count_up";
                idle(4, 1'b0);
                test_name = "taken_miss";
                run_cycle(1'b0, 1'b1, {branch_pkg::OP_JMP, 12'h123}, 16'h0040, 16'h0041, '0, '0);
                idle(1, 1'b0);
                test_name = "btb_hit";
                jump_fetch_to(16'h0040);
                run_cycle(1'b0, 1'b1, {branch_pkg::OP_JMP, 12'h123}, 16'h0040, 16'h0123, '0, '0);
                // weak taken, one not taken, then two taken
                test_name = "hysteresis";
                instr = {branch_pkg::OP_BEQ, 4'b0110, 8'h10};
                run_cycle(1'b0, 1'b1, instr, 16'h0085, 16'h0086, 16'd5, 16'd5);
                run_cycle(1'b0, 1'b1, instr, 16'h0085, 16'h0096, 16'd5, 16'd6);
                jump_fetch_to(16'h0085);
                idle(1, 1'b0);
                repeat (2) run_cycle(1'b0, 1'b1, instr, 16'h0085, 16'h0086, 16'd7, 16'd7);
                jump_fetch_to(16'h0085);
                idle(1, 1'b0);
                test_name = "stall";
                idle(3, 1'b1);
                idle(1, 1'b0);
                test_name = "random";
                repeat (NUM_RANDOM) begin
                        k = $urandom_range(0, 5);
                        case ($urandom_range(0, 9))
                                0: idle($urandom_range(1, 3), 1'b1);
                                1: idle(1, 1'b0);
                                2: jump_fetch_to(pool[k]);
                                default: begin
                                        rt = $urandom;
                                        rs = $urandom;
                                        if ($urandom_range(0, 2) == 0)
                                                rs = rt;
                                        instr        = $urandom;
                                        op           = $urandom_range(0, 5);
                                        instr[15:12] = (op < 4) ? op :
                                                       (op == 4) ? branch_pkg::OP_JMP : 4'd6;
                                        pred = $urandom_range(0, 1) ? pool_pred[k] : pool[k] + 16'd1;
                                        run_cycle(1'b0, 1'b1, instr, pool[k], pred, rs, rt);
                                end
                        endcase
                end
                check_en = 1'b0;
                $display("random steps: %0d, errors: %0d", NUM_RANDOM, errors);
                if (errors == 0)
                        $display("Test passed");
                else
                        $display("Test failed");
                $finish;
        end

        // watchdog
        initial begin
                #((NUM_CYCLES + 20) * 40);
                $display("Timeout: stimulus did not complete, errors so far: %0d", errors);
                $display("Test failed");
                $finish;
        end

endmodule

`default_nettype wire

// ==== files.f ====
branch_pkg.sv
resolve_if.sv
branch_resolver.sv
branch_predictor.sv
fetch_pc_unit.sv
branch_unit.sv
branch_checker.sv
tb_branch_unit.sv
